//--- logic/bpu_pkg.sv
////////////////////////////////////////
// Shared definitions for the branch prediction unit.
// Widths, the branch type encoding and the packed records
// exchanged with the FTQ. Modules import what they need.
////////////////////////////////////////
package bpu_pkg;

    // PC and fetch block geometry
    parameter int ADDR_WIDTH     = 32;
    parameter int FETCH_WIDTH    = 4;
    parameter int LEN_WIDTH      = 3;
    // Counter field carried in the meta, modules use the low bits
    parameter int META_CTR_WIDTH = 4;

    typedef enum logic [1:0] {
        BRANCH_COND   = 2'd0,
        BRANCH_CALL   = 2'd1,
        BRANCH_RET    = 2'd2,
        BRANCH_UNCOND = 2'd3
    } branch_type_t;

    // Fetch block handed to the FTQ
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [LEN_WIDTH-1:0]  length;
        logic                  is_cross_cacheline;
        logic                  predicted_taken;
        logic                  predict_valid;
    } ftq_block_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] tag;
        branch_type_t          branch_type;
        logic                  is_cross_cacheline;
        logic [ADDR_WIDTH-1:0] jump_target;
        logic [ADDR_WIDTH-1:0] fall_through;
    } ftb_entry_t;

    // Prediction state returned with every training record
    typedef struct packed {
        logic                      ftb_hit;
        logic [META_CTR_WIDTH-1:0] ctr;
    } bpu_meta_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] start_pc;
        branch_type_t          branch_type;
        logic                  is_taken;
        logic                  predicted_taken;
        logic                  is_cross_cacheline;
        logic                  ftb_dirty;
        logic [ADDR_WIDTH-1:0] jump_target;
        logic [ADDR_WIDTH-1:0] fall_through;
        bpu_meta_t             meta;
    } ftq_train_t;

endpackage

//--- logic/ftb.sv
////////////////////////////////////////
// Direct-mapped fetch target buffer.
// Lookup is registered, so hit and entry appear one cycle
// after query_pc_i. A write with a clear valid bit drops the set.
////////////////////////////////////////
module ftb #(
    parameter int FTB_NSET = 16
) (
    input  logic                          clk,
    input  logic                          rst_n_i,

    input  logic [bpu_pkg::ADDR_WIDTH-1:0] query_pc_i,
    output logic                          hit_o,
    output bpu_pkg::ftb_entry_t           entry_o,

    input  logic                          update_valid_i,
    input  logic [bpu_pkg::ADDR_WIDTH-1:0] update_pc_i,
    input  bpu_pkg::ftb_entry_t           update_entry_i
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(FTB_NSET);

    ftb_entry_t            table_q [FTB_NSET];
    logic [FTB_NSET-1:0]   valid_bits_q;

    logic [IDX_W-1:0]      query_idx;
    logic [IDX_W-1:0]      update_idx;
    logic [ADDR_WIDTH-1:0] query_tag;

    ftb_entry_t            entry_q;
    logic                  valid_q;
    logic                  hit_q;

    // Index sits just above the word offset
    assign query_idx  = query_pc_i[IDX_W+1:2];
    assign update_idx = update_pc_i[IDX_W+1:2];
    // Tag is zero extended, upper bits stay clear for bigger tables
    assign query_tag  = ADDR_WIDTH'(query_pc_i[ADDR_WIDTH-1:IDX_W+2]);

    ////////////////////////////////////////
    // Valid bits and registered compare
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_bits_q <= '0;
            valid_q      <= 1'b0;
            hit_q        <= 1'b0;
        end else begin
            valid_q <= valid_bits_q[query_idx];
            hit_q   <= valid_bits_q[query_idx] && (table_q[query_idx].tag == query_tag);
            if (update_valid_i) begin
                valid_bits_q[update_idx] <= update_entry_i.valid;
            end
        end
    end

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        entry_q <= table_q[query_idx];
        if (update_valid_i) begin
            table_q[update_idx] <= update_entry_i;
        end
    end

    assign hit_o = hit_q;

    // Valid in the entry reflects the reset-cleared bit vector
    always_comb begin
        entry_o       = entry_q;
        entry_o.valid = valid_q;
    end

endmodule

//--- logic/bimodal_predictor.sv
////////////////////////////////////////
// Bimodal direction predictor.
// One saturating counter per set, registered lookup.
// Training moves the counter from the meta one step.
////////////////////////////////////////
module bimodal_predictor #(
    parameter int FTB_NSET  = 16,
    parameter int CTR_WIDTH = 2
) (
    input  logic                              clk,
    input  logic                              rst_n_i,

    input  logic [bpu_pkg::ADDR_WIDTH-1:0]     query_pc_i,
    output logic [bpu_pkg::META_CTR_WIDTH-1:0] ctr_o,

    input  logic                              update_valid_i,
    input  logic [bpu_pkg::ADDR_WIDTH-1:0]     update_pc_i,
    input  logic                              update_taken_i,
    input  logic [bpu_pkg::META_CTR_WIDTH-1:0] update_ctr_i
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(FTB_NSET);
    localparam logic [CTR_WIDTH-1:0] CTR_MAX  = '1;
    // Weakly not-taken
    localparam logic [CTR_WIDTH-1:0] CTR_WEAK = CTR_WIDTH'((1 << (CTR_WIDTH - 1)) - 1);

    logic [CTR_WIDTH-1:0] ctr_table_q [FTB_NSET];
    logic [CTR_WIDTH-1:0] ctr_q;
    logic [CTR_WIDTH-1:0] old_ctr;
    logic [CTR_WIDTH-1:0] new_ctr;

    assign old_ctr = update_ctr_i[CTR_WIDTH-1:0];

    // Saturate at both ends
    always_comb begin
        new_ctr = old_ctr;
        if (update_taken_i && (old_ctr != CTR_MAX)) begin
            new_ctr = old_ctr + 1'b1;
        end else if (!update_taken_i && (old_ctr != '0)) begin
            new_ctr = old_ctr - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < FTB_NSET; i++) begin
                ctr_table_q[i] <= CTR_WEAK;
            end
            ctr_q <= CTR_WEAK;
        end else begin
            ctr_q <= ctr_table_q[query_pc_i[IDX_W+1:2]];
            if (update_valid_i) begin
                ctr_table_q[update_pc_i[IDX_W+1:2]] <= new_ctr;
            end
        end
    end

    assign ctr_o = META_CTR_WIDTH'(ctr_q);

endmodule

//--- logic/ras.sv
////////////////////////////////////////
// Return address stack, circular.
// Overflow overwrites the oldest entry; push wins over pop.
////////////////////////////////////////
module ras #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          push_i,
    input  logic [bpu_pkg::ADDR_WIDTH-1:0] push_addr_i,
    input  logic                          pop_i,
    output logic [bpu_pkg::ADDR_WIDTH-1:0] top_addr_o
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [ADDR_WIDTH-1:0] stack_q [RAS_DEPTH];
    logic [PTR_W-1:0]      ptr_q;
    logic [PTR_W-1:0]      ptr_inc;
    logic [PTR_W-1:0]      ptr_dec;

    // Wrap explicitly so any depth works
    assign ptr_inc = (ptr_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
    assign ptr_dec = (ptr_q == '0) ? PTR_W'(RAS_DEPTH - 1) : ptr_q - 1'b1;

    // Pointer names the current top
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (push_i) begin
            ptr_q <= ptr_inc;
        end else if (pop_i) begin
            ptr_q <= ptr_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[ptr_inc] <= push_addr_i;
        end
    end

    assign top_addr_o = stack_q[ptr_q];

endmodule

//--- logic/bpu.sv
////////////////////////////////////////
// Branch prediction unit, top level.
// P0 sends a next-line block, P1 may override it with an FTB,
// counter and RAS based redirect. One FTQ training record a cycle.
////////////////////////////////////////
module bpu #(
    parameter int FTB_NSET  = 16,
    parameter int CTR_WIDTH = 2,
    parameter int RAS_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n_i,

    input  logic [bpu_pkg::ADDR_WIDTH-1:0] pc_i,
    input  logic                          ftq_full_i,
    input  logic                          backend_flush_i,
    input  bpu_pkg::ftq_train_t           ftq_train_i,

    output bpu_pkg::ftq_block_t           ftq_p0_o,
    output bpu_pkg::ftq_block_t           ftq_p1_o,
    output bpu_pkg::bpu_meta_t            meta_o,
    output logic                          redirect_o,
    output logic [bpu_pkg::ADDR_WIDTH-1:0] redirect_pc_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(FTB_NSET);

    logic [ADDR_WIDTH-1:0]     p1_pc_q;
    logic                      flush_q;
    logic                      full_q;
    logic                      redirect;

    logic                      ftb_hit;
    ftb_entry_t                ftb_entry;
    logic [META_CTR_WIDTH-1:0] ctr;
    logic                      ctr_taken;
    logic [ADDR_WIDTH-1:0]     ras_top;

    logic                      page_end;
    logic [11:0]               page_left;

    logic                      ftb_update_valid;
    ftb_entry_t                ftb_update_entry;
    logic                      mispredict;
    logic                      dirty_hit;
    logic                      ctr_update_valid;
    logic                      ras_push;
    logic                      ras_pop;

    ////////////////////////////////////////
    // P0 next-line block
    ////////////////////////////////////////
    // Four words would run past the 4 KiB page
    assign page_end  = pc_i[11:0] > 12'hFF0;
    assign page_left = 12'h000 - pc_i[11:0];

    always_comb begin
        ftq_p0_o = '0;
        if (!ftq_full_i) begin
            ftq_p0_o.valid    = 1'b1;
            ftq_p0_o.start_pc = pc_i;
            ftq_p0_o.length   = page_end ? page_left[LEN_WIDTH+1:2] : LEN_WIDTH'(FETCH_WIDTH);
            // A truncated block ends on the page edge, so it never crosses a line
            ftq_p0_o.is_cross_cacheline = (pc_i[3:2] != 2'b00) && !page_end;
        end
    end

    ////////////////////////////////////////
    // P1 override
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        p1_pc_q <= pc_i;
    end

    // Reset counts as a flush, so the first P1 cycle never redirects
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            flush_q <= 1'b1;
            full_q  <= 1'b0;
        end else begin
            flush_q <= backend_flush_i | redirect;
            full_q  <= ftq_full_i;
        end
    end

    assign redirect   = ftb_hit & ~flush_q & ~full_q;
    assign redirect_o = redirect;
    assign ctr_taken  = ctr[CTR_WIDTH-1];

    always_comb begin
        case (ftb_entry.branch_type)
            BRANCH_COND:   redirect_pc_o = ctr_taken ? ftb_entry.jump_target
                                                     : ftb_entry.fall_through;
            BRANCH_RET:    redirect_pc_o = ras_top;
            default:       redirect_pc_o = ftb_entry.jump_target;
        endcase
    end

    // Unconditional jumps redirect without a corrected block
    always_comb begin
        ftq_p1_o = '0;
        if (redirect && (ftb_entry.branch_type != BRANCH_UNCOND)) begin
            ftq_p1_o.valid              = 1'b1;
            ftq_p1_o.start_pc           = p1_pc_q;
            // Modulo 8 word distance to the fall-through
            ftq_p1_o.length             = ftb_entry.fall_through[LEN_WIDTH+1:2]
                                        - p1_pc_q[LEN_WIDTH+1:2];
            ftq_p1_o.is_cross_cacheline = ftb_entry.is_cross_cacheline;
            ftq_p1_o.predicted_taken    = (ftb_entry.branch_type == BRANCH_COND) ? ctr_taken
                                                                                  : 1'b1;
            ftq_p1_o.predict_valid      = 1'b1;
        end
    end

    assign meta_o.ftb_hit = ftb_hit;
    assign meta_o.ctr     = ctr;

    ////////////////////////////////////////
    // Training decode
    ////////////////////////////////////////
    assign mispredict = ftq_train_i.predicted_taken ^ ftq_train_i.is_taken;
    assign dirty_hit  = ftq_train_i.ftb_dirty & ftq_train_i.meta.ftb_hit;

    // New branch seen taken, or a polluted entry to drop
    assign ftb_update_valid = ftq_train_i.valid
                            & (ftq_train_i.branch_type != BRANCH_UNCOND)
                            & ((mispredict & ~ftq_train_i.meta.ftb_hit) | dirty_hit);

    always_comb begin
        ftb_update_entry.valid              = ~dirty_hit;
        ftb_update_entry.tag                = ADDR_WIDTH'(ftq_train_i.start_pc[ADDR_WIDTH-1:IDX_W+2]);
        ftb_update_entry.branch_type        = ftq_train_i.branch_type;
        ftb_update_entry.is_cross_cacheline = ftq_train_i.is_cross_cacheline;
        ftb_update_entry.jump_target        = ftq_train_i.jump_target;
        ftb_update_entry.fall_through       = ftq_train_i.fall_through;
    end

    assign ctr_update_valid = ftq_train_i.valid & (ftq_train_i.branch_type == BRANCH_COND);
    assign ras_push         = ftq_train_i.valid & (ftq_train_i.branch_type == BRANCH_CALL);
    assign ras_pop          = ftq_train_i.valid & (ftq_train_i.branch_type == BRANCH_RET);

    ////////////////////////////////////////
    // Predictors
    ////////////////////////////////////////
    ftb #(
        .FTB_NSET(FTB_NSET)
    ) u_ftb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .query_pc_i    (pc_i),
        .hit_o         (ftb_hit),
        .entry_o       (ftb_entry),
        .update_valid_i(ftb_update_valid),
        .update_pc_i   (ftq_train_i.start_pc),
        .update_entry_i(ftb_update_entry)
    );

    bimodal_predictor #(
        .FTB_NSET (FTB_NSET),
        .CTR_WIDTH(CTR_WIDTH)
    ) u_bimodal (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .query_pc_i    (pc_i),
        .ctr_o         (ctr),
        .update_valid_i(ctr_update_valid),
        .update_pc_i   (ftq_train_i.start_pc),
        .update_taken_i(ftq_train_i.is_taken),
        .update_ctr_i  (ftq_train_i.meta.ctr)
    );

    ras #(
        .RAS_DEPTH(RAS_DEPTH)
    ) u_ras (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .push_i     (ras_push),
        .push_addr_i(ftq_train_i.fall_through),
        .pop_i      (ras_pop),
        .top_addr_o (ras_top)
    );

endmodule

//--- sim/bpu_assert.sv
////////////////////////////////////////
// Protocol assertions for the BPU outputs.
// Bound into every bpu instance.
////////////////////////////////////////
module bpu_assert (
    input logic                clk,
    input logic                rst_n_i,
    input logic                flush_i,
    input logic                redirect_i,
    input bpu_pkg::ftq_block_t p1_block_i
);

    // Failure count, read by the testbench at the end of the run
    int violations = 0;

    // A redirect or flush blanks the next P1 cycle
    a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n_i)
        (redirect_i || flush_i) |=> !redirect_i)
    else begin
        violations++;
        $error("redirect in the cycle after a redirect or flush");
    end

    a_p1_needs_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        p1_block_i.valid |-> redirect_i)
    else begin
        violations++;
        $error("P1 block valid without a redirect");
    end

endmodule

bind bpu bpu_assert u_bpu_assert (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .flush_i   (backend_flush_i),
    .redirect_i(redirect_o),
    .p1_block_i(ftq_p1_o)
);

//--- sim/bpu_tb.sv
////////////////////////////////////////
// Testbench for the branch prediction unit.
// Applies a stimulus table one step per cycle and checks P0,
// and one cycle later P1, against a small reference model.
////////////////////////////////////////
module bpu_tb;
    import bpu_pkg::*;

    localparam int NSET  = 16;
    localparam int CTR_W = 2;
    localparam int RAS_D = 8;
    localparam int IDX_W = $clog2(NSET);
    localparam logic [CTR_W-1:0] CTR_MAX = '1;

    localparam logic [ADDR_WIDTH-1:0] B_PC  = 32'h0000_1008;
    localparam logic [ADDR_WIDTH-1:0] B_JT  = 32'h0000_2000;
    localparam logic [ADDR_WIDTH-1:0] B_FT  = 32'h0000_1014;
    localparam logic [ADDR_WIDTH-1:0] C1_PC = 32'h0000_3010;
    localparam logic [ADDR_WIDTH-1:0] C2_PC = 32'h0000_5020;
    localparam logic [ADDR_WIDTH-1:0] R_PC  = 32'h0000_6030;

    // One table row, a zero pc means a random filler PC
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        logic                  full;
        logic                  flush;
        ftq_train_t            train;
        logic                  exp_redir;
    } step_t;

    logic clk;
    logic rst_n_i;
    logic [ADDR_WIDTH-1:0] pc_i;
    logic ftq_full_i;
    logic backend_flush_i;
    ftq_train_t ftq_train_i;
    ftq_block_t ftq_p0_o;
    ftq_block_t ftq_p1_o;
    bpu_meta_t meta_o;
    logic redirect_o;
    logic [ADDR_WIDTH-1:0] redirect_pc_o;

    step_t tab[$];
    string names[$];
    ftb_entry_t m_ftb[NSET];
    logic [CTR_W-1:0] m_ctr[NSET];
    logic [ADDR_WIDTH-1:0] m_ras[RAS_D];
    int m_ptr;
    logic [15:0] lfsr;
    int err_count;
    int pass_tests;
    int fail_tests;

    bpu #(
        .FTB_NSET (NSET),
        .CTR_WIDTH(CTR_W),
        .RAS_DEPTH(RAS_D)
    ) UUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pc_i           (pc_i),
        .ftq_full_i     (ftq_full_i),
        .backend_flush_i(backend_flush_i),
        .ftq_train_i    (ftq_train_i),
        .ftq_p0_o       (ftq_p0_o),
        .ftq_p1_o       (ftq_p1_o),
        .meta_o         (meta_o),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] random_pc();
        logic [ADDR_WIDTH-1:0] pc;
        pc = '0;
        for (int i = 2; i < ADDR_WIDTH; i++) begin
            pc[i] = next_bit();
        end
        return pc;
    endfunction

    // Clock level wait, bounded by a few clock events
    task automatic wait_clk(input logic level);
        int n;
        n = 0;
        do begin
            @(clk);
            n++;
        end while ((clk !== level) && (n < 4));
        if (clk !== level) begin
            $display("Timeout: the clock never reached level %b", level);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    function automatic ftq_train_t make_train(input branch_type_t bt,
                                              input logic [ADDR_WIDTH-1:0] pc,
                                              input logic taken, input logic pred,
                                              input logic dirty,
                                              input logic [ADDR_WIDTH-1:0] jt,
                                              input logic [ADDR_WIDTH-1:0] ft);
        ftq_train_t t;
        t                    = '0;
        t.valid              = 1'b1;
        t.start_pc           = pc;
        t.branch_type        = bt;
        t.is_taken           = taken;
        t.predicted_taken    = pred;
        t.is_cross_cacheline = (pc[3:2] != 2'b00);
        t.ftb_dirty          = dirty;
        t.jump_target        = jt;
        t.fall_through       = ft;
        return t;
    endfunction

    function automatic ftq_train_t cond_train(input logic taken, input logic pred,
                                              input logic dirty);
        return make_train(BRANCH_COND, B_PC, taken, pred, dirty, B_JT, B_FT);
    endfunction

    task automatic add_step(input string name, input logic [ADDR_WIDTH-1:0] pc,
                            input logic full, input logic flush,
                            input ftq_train_t train, input logic exp_redir);
        step_t s;
        s = '{(pc == '0) ? random_pc() : pc, full, flush, train, exp_redir};
        tab.push_back(s);
        names.push_back(name);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic model_hit(input logic [ADDR_WIDTH-1:0] pc);
        ftb_entry_t e;
        e = m_ftb[pc[IDX_W+1:2]];
        return e.valid && (e.tag == ADDR_WIDTH'(pc >> (IDX_W + 2)));
    endfunction

    task automatic model_ras(input ftq_train_t t);
        if (t.valid && (t.branch_type == BRANCH_CALL)) begin
            m_ptr        = (m_ptr + 1) % RAS_D;
            m_ras[m_ptr] = t.fall_through;
        end else if (t.valid && (t.branch_type == BRANCH_RET)) begin
            m_ptr = (m_ptr + RAS_D - 1) % RAS_D;
        end
    endtask

    task automatic model_train(input ftq_train_t t);
        int i;
        logic dirty_hit;
        logic [CTR_W-1:0] old;
        i         = t.start_pc[IDX_W+1:2];
        dirty_hit = t.ftb_dirty && t.meta.ftb_hit;
        old       = t.meta.ctr[CTR_W-1:0];
        if (t.valid && (t.branch_type != BRANCH_UNCOND) &&
            (((t.is_taken != t.predicted_taken) && !t.meta.ftb_hit) || dirty_hit)) begin
            m_ftb[i].valid              = !dirty_hit;
            m_ftb[i].tag                = ADDR_WIDTH'(t.start_pc >> (IDX_W + 2));
            m_ftb[i].branch_type        = t.branch_type;
            m_ftb[i].is_cross_cacheline = t.is_cross_cacheline;
            m_ftb[i].jump_target        = t.jump_target;
            m_ftb[i].fall_through       = t.fall_through;
        end
        if (t.valid && (t.branch_type == BRANCH_COND)) begin
            if (t.is_taken) begin
                m_ctr[i] = (old == CTR_MAX) ? old : old + 1'b1;
            end else begin
                m_ctr[i] = (old == '0) ? old : old - 1'b1;
            end
        end
    endtask

    // Expected P1 results for one table row
    task automatic model_p1(input step_t s, output ftq_block_t blk,
                            output bpu_meta_t meta, output logic [ADDR_WIDTH-1:0] target);
        ftb_entry_t e;
        logic [CTR_W-1:0] c;
        e            = m_ftb[s.pc[IDX_W+1:2]];
        c            = m_ctr[s.pc[IDX_W+1:2]];
        meta.ftb_hit = model_hit(s.pc);
        meta.ctr     = META_CTR_WIDTH'(c);
        case (e.branch_type)
            BRANCH_COND: target = c[CTR_W-1] ? e.jump_target : e.fall_through;
            BRANCH_RET:  target = m_ras[m_ptr];
            default:     target = e.jump_target;
        endcase
        blk = '0;
        if (s.exp_redir && (e.branch_type != BRANCH_UNCOND)) begin
            blk.valid              = 1'b1;
            blk.start_pc           = s.pc;
            blk.length             = e.fall_through[4:2] - s.pc[4:2];
            blk.is_cross_cacheline = e.is_cross_cacheline;
            blk.predicted_taken    = (e.branch_type == BRANCH_COND) ? c[CTR_W-1] : 1'b1;
            blk.predict_valid      = 1'b1;
        end
    endtask

    // Next-line block, cut at the 4 KiB page end
    function automatic ftq_block_t p0_expect(input logic [ADDR_WIDTH-1:0] pc,
                                             input logic full);
        ftq_block_t b;
        logic [12:0] left;
        b    = '0;
        left = 13'h1000 - pc[11:0];
        if (!full) begin
            b.valid              = 1'b1;
            b.start_pc           = pc;
            b.length             = (left < 13'd16) ? left[4:2] : 3'd4;
            b.is_cross_cacheline = (pc[3:2] != 2'b00) && (left >= 13'd16);
        end
        return b;
    endfunction

    ////////////////////////////////////////
    // Compare tasks and report
    ////////////////////////////////////////
    task automatic check_block(input string what, input ftq_block_t got,
                               input ftq_block_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_redirect(input logic got_r, input logic [ADDR_WIDTH-1:0] got_pc,
                                  input logic exp_r, input logic [ADDR_WIDTH-1:0] exp_pc);
        if ((got_r !== exp_r) || (exp_r && (got_pc !== exp_pc))) begin
            $display("[FAIL] t=%0t redirect: got %b/%h expected %b/%h",
                     $time, got_r, got_pc, exp_r, exp_pc);
            err_count++;
        end
    endtask

    task automatic check_meta(input bpu_meta_t got, input bpu_meta_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t meta: got %h expected %h", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            pass_tests++;
            $display("test %-18s ok", name);
        end else begin
            fail_tests++;
            $display("test %-18s %0d mismatches", name, errs);
        end
    endtask

    task automatic build_table();
        add_step("p0 cross", 32'h0000_7FE4, 0, 0, '0, 0);
        add_step("p0 page end 3", 32'h0000_7FF4, 0, 0, '0, 0);
        add_step("p0 page end 2", 32'h0000_7FF8, 0, 0, '0, 0);
        add_step("p0 page end 1", 32'h0000_7FFC, 0, 0, '0, 0);
        add_step("p0 full", 32'h0000_1000, 1, 0, '0, 0);
        add_step("learn cond", 0, 0, 0, cond_train(0, 1, 0), 0);
        add_step("query cond nt", B_PC, 0, 0, '0, 1);
        add_step("after redirect", B_PC, 0, 0, '0, 0);
        add_step("taken 1", 0, 0, 0, cond_train(1, 0, 0), 0);
        add_step("taken 2", 0, 0, 0, cond_train(1, 0, 0), 0);
        add_step("query weak t", B_PC, 0, 0, '0, 1);
        add_step("taken 3", 0, 0, 0, cond_train(1, 0, 0), 0);
        add_step("taken sat", 0, 0, 0, cond_train(1, 1, 0), 0);
        add_step("query strong t", B_PC, 0, 0, '0, 1);
        add_step("not taken 1", 0, 0, 0, cond_train(0, 1, 0), 0);
        add_step("not taken 2", 0, 0, 0, cond_train(0, 1, 0), 0);
        add_step("not taken 3", 0, 0, 0, cond_train(0, 1, 0), 0);
        add_step("not taken sat", 0, 0, 0, cond_train(0, 0, 0), 0);
        add_step("query strong nt", B_PC, 0, 0, '0, 1);
        add_step("learn ret", 0, 0, 0,
                 make_train(BRANCH_RET, R_PC, 1, 0, 0, 32'h0, R_PC + 4), 0);
        add_step("call outer", 0, 0, 0,
                 make_train(BRANCH_CALL, C1_PC, 1, 0, 0, C2_PC, C1_PC + 4), 0);
        add_step("call inner", 0, 0, 0,
                 make_train(BRANCH_CALL, C2_PC, 1, 0, 0, R_PC, C2_PC + 4), 0);
        add_step("return inner", R_PC, 0, 0, '0, 1);
        add_step("pop inner", 0, 0, 0,
                 make_train(BRANCH_RET, R_PC, 1, 1, 0, 32'h0, R_PC + 4), 0);
        add_step("return outer", R_PC, 0, 0, '0, 1);
        add_step("filler", 0, 0, 0, '0, 0);
        add_step("flush blocks", B_PC, 0, 1, '0, 0);
        add_step("full blocks", B_PC, 1, 0, '0, 0);
        add_step("query again", B_PC, 0, 0, '0, 1);
        add_step("dirty drop", 0, 0, 0, cond_train(0, 0, 1), 0);
        add_step("query dropped", B_PC, 0, 0, '0, 0);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        step_t cur;
        step_t prev;
        ftq_block_t exp_p1;
        bpu_meta_t exp_meta;
        logic [ADDR_WIDTH-1:0] exp_pc;
        int e0;
        int e1;
        int p0_errs;

        rst_n_i         = 1'b0;
        pc_i            = '0;
        ftq_full_i      = 1'b0;
        backend_flush_i = 1'b0;
        ftq_train_i     = '0;
        lfsr            = 16'd62180;
        err_count       = 0;
        pass_tests      = 0;
        fail_tests      = 0;
        m_ptr           = 0;
        for (int i = 0; i < NSET; i++) begin
            m_ftb[i] = '0;
            m_ctr[i] = CTR_W'((1 << (CTR_W - 1)) - 1);
        end
        for (int i = 0; i < RAS_D; i++) begin
            m_ras[i] = '0;
        end
        build_table();

        repeat (3) wait_clk(1'b1);
        rst_n_i <= 1'b1;
        prev    = '0;
        p0_errs = 0;

        // Row k drives P0 now, its P1 is checked on the next row
        for (int k = 0; k <= tab.size(); k++) begin
            wait_clk(1'b1);
            if (k < tab.size()) begin
                cur = tab[k];
            end else begin
                cur = '0;
            end
            if (k > 0) begin
                model_ras(prev.train);
                model_p1(prev, exp_p1, exp_meta, exp_pc);
                model_train(prev.train);
            end
            cur.train.meta.ftb_hit = model_hit(cur.train.start_pc);
            cur.train.meta.ctr     = META_CTR_WIDTH'(m_ctr[cur.train.start_pc[IDX_W+1:2]]);
            pc_i            <= cur.pc;
            ftq_full_i      <= cur.full;
            backend_flush_i <= cur.flush;
            ftq_train_i     <= cur.train;

            wait_clk(1'b0);
            e0 = err_count;
            if (k > 0) begin
                check_redirect(redirect_o, redirect_pc_o, prev.exp_redir, exp_pc);
                check_block("P1 block", ftq_p1_o, exp_p1);
                check_meta(meta_o, exp_meta);
            end
            e1 = err_count;
            if (k < tab.size()) begin
                check_block("P0 block", ftq_p0_o, p0_expect(cur.pc, cur.full));
            end
            if (k > 0) begin
                report_test(names[k-1], p0_errs + e1 - e0);
            end
            p0_errs = err_count - e1;
            prev    = cur;
        end

        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 pass_tests + fail_tests, pass_tests, fail_tests,
                 UUT.u_bpu_assert.violations);
        if ((err_count == 0) && (UUT.u_bpu_assert.violations == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/bpu_pkg.sv
logic/ftb.sv
logic/bimodal_predictor.sv
logic/ras.sv
logic/bpu.sv
sim/bpu_assert.sv
sim/bpu_tb.sv
